// File: hdl/mos6502Pkg.sv
/* shared types and constants for the APB hosted 6502 datapath
   register map, opcode union, control word, ALU result and status layout */
package mos6502Pkg;

  // bus widths
  localparam int DATA_W     = 8;
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // APB register map
  localparam logic [APB_ADDR_W-1:0] ADDR_INSTR = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_A     = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_X     = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_Y     = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_S     = 8'h10;
  localparam logic [APB_ADDR_W-1:0] ADDR_P     = 8'h14;

  // group 1 field codes, cc and bbb
  localparam logic [1:0] GRP1_CC = 2'b01;
  localparam logic [2:0] BBB_IMM = 3'b010;

  // group 1 operation field
  localparam logic [2:0] AAA_ORA = 3'b000;
  localparam logic [2:0] AAA_AND = 3'b001;
  localparam logic [2:0] AAA_EOR = 3'b010;
  localparam logic [2:0] AAA_ADC = 3'b011;
  localparam logic [2:0] AAA_STA = 3'b100;
  localparam logic [2:0] AAA_LDA = 3'b101;
  localparam logic [2:0] AAA_CMP = 3'b110;
  localparam logic [2:0] AAA_SBC = 3'b111;

  // implied opcodes
  localparam logic [7:0] OP_TAX = 8'hAA;
  localparam logic [7:0] OP_TAY = 8'hA8;
  localparam logic [7:0] OP_TXA = 8'h8A;
  localparam logic [7:0] OP_TYA = 8'h98;
  localparam logic [7:0] OP_TSX = 8'hBA;
  localparam logic [7:0] OP_TXS = 8'h9A;
  localparam logic [7:0] OP_CLC = 8'h18;
  localparam logic [7:0] OP_SEC = 8'h38;
  localparam logic [7:0] OP_CLI = 8'h58;
  localparam logic [7:0] OP_SEI = 8'h78;
  localparam logic [7:0] OP_CLV = 8'hB8;
  localparam logic [7:0] OP_NOP = 8'hEA;

  // reset values, P has the unused one and I set
  localparam logic [DATA_W-1:0] P_RESET   = 8'h24;
  localparam logic [DATA_W-1:0] S_RESET   = 8'hFF;
  localparam logic [DATA_W-1:0] REG_RESET = 8'h00;

  // aaa bbb cc split of an opcode
  typedef struct packed {
    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
  } opFieldsT;

  typedef union packed {
    logic [7:0] raw;
    opFieldsT   grp;
  } opcodeWordT;

  typedef enum logic [2:0] {ALU_OR, ALU_AND, ALU_EOR, ALU_SUM, ALU_PASS} aluOpT;
  typedef enum logic [2:0] {BUS_A, BUS_X, BUS_Y, BUS_S, BUS_OPERAND} busSrcT;
  typedef enum logic [2:0] {DEST_NONE, DEST_A, DEST_X, DEST_Y, DEST_S} regDestT;
  typedef enum logic [1:0] {FLAGS_NONE, FLAGS_NZ, FLAGS_NZC, FLAGS_NZVC} flagModeT;
  typedef enum logic [2:0] {FOP_NONE, FOP_CLC, FOP_SEC, FOP_CLI, FOP_SEI, FOP_CLV} flagOpT;

  typedef struct packed {
    busSrcT   busSrc;
    aluOpT    aluOp;
    logic     invertB;
    logic     carryFromFlag;
    regDestT  regDest;
    flagModeT flagMode;
    flagOpT   flagOp;
  } ctrlWordT;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              carry;
    logic              overflow;
    logic              zero;
    logic              negative;
  } aluResultT;

  // bit order as the P register
  typedef struct packed {
    logic n;
    logic v;
    logic one;
    logic b;
    logic d;
    logic i;
    logic z;
    logic c;
  } statusT;

endpackage

// File: hdl/apbHostPort.sv
`timescale 1ns/1ps
/* APB slave for instruction issue and register read-back
   busy wait states, error response and read mux */
module apbHostPort (
  input  logic                              phi2,
  input  logic                              rstN,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [mos6502Pkg::APB_ADDR_W-1:0] paddr,
  input  logic [mos6502Pkg::APB_DATA_W-1:0] pwdata,
  output logic [mos6502Pkg::APB_DATA_W-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr,
  output mos6502Pkg::opcodeWordT            opcode,
  input  mos6502Pkg::ctrlWordT              ctrl,
  input  logic                              illegal,
  input  logic                              busy,
  output logic                              issue,
  output mos6502Pkg::ctrlWordT              issueCtrl,
  output logic [mos6502Pkg::DATA_W-1:0]     operand,
  input  logic [mos6502Pkg::DATA_W-1:0]     regA,
  input  logic [mos6502Pkg::DATA_W-1:0]     regX,
  input  logic [mos6502Pkg::DATA_W-1:0]     regY,
  input  logic [mos6502Pkg::DATA_W-1:0]     regS,
  input  mos6502Pkg::statusT                status
);
  import mos6502Pkg::*;

  logic        access;
  logic        done;
  logic        instrHit;
  logic        readHit;
  logic        accept;
  logic [15:0] lastInstr;

  // access phase, held off while the core works
  assign access   = psel & penable;
  assign pready   = ~(access & busy);
  assign done     = access & pready;
  assign instrHit = (paddr == ADDR_INSTR);

  // opcode byte straight to the decoder
  assign opcode.raw = pwdata[7:0];

  // read-back mux, zero extended
  always_comb begin
    readHit = 1'b1;
    prdata  = '0;
    case (paddr)
      ADDR_INSTR: prdata[15:0] = lastInstr;
      ADDR_A:     prdata[7:0] = regA;
      ADDR_X:     prdata[7:0] = regX;
      ADDR_Y:     prdata[7:0] = regY;
      ADDR_S:     prdata[7:0] = regS;
      ADDR_P:     prdata[7:0] = status;
      default:    readHit = 1'b0;
    endcase
  end

  // only instr is writable, and only with a known opcode
  assign pslverr = done & (pwrite ? (~instrHit | illegal) : ~readHit);
  assign accept  = done & pwrite & instrHit & ~illegal;

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      issue     <= 1'b0;
      lastInstr <= '0;
    end else begin
      issue <= accept;
      if (accept)
        lastInstr <= pwdata[15:0];
    end
  end

  // payload for the sequencer
  always_ff @(posedge phi2) begin
    if (accept) begin
      issueCtrl <= ctrl;
      operand   <= pwdata[15:8];
    end
  end

endmodule

// File: hdl/opcodeDecode.sv
`timescale 1ns/1ps
/* opcode decode into a control word, group 1 immediate and implied ops */
module opcodeDecode (
  input  mos6502Pkg::opcodeWordT opcode,
  output mos6502Pkg::ctrlWordT   ctrl,
  output logic                   illegal
);
  import mos6502Pkg::*;

  always_comb begin
    // behaves as NOP unless overridden
    ctrl.busSrc        = BUS_A;
    ctrl.aluOp         = ALU_PASS;
    ctrl.invertB       = 1'b0;
    ctrl.carryFromFlag = 1'b0;
    ctrl.regDest       = DEST_NONE;
    ctrl.flagMode      = FLAGS_NONE;
    ctrl.flagOp        = FOP_NONE;
    illegal            = 1'b0;

    if (opcode.grp.cc == GRP1_CC && opcode.grp.bbb == BBB_IMM) begin
      // accumulator against the immediate operand
      ctrl.regDest       = DEST_A;
      ctrl.flagMode      = FLAGS_NZ;
      ctrl.carryFromFlag = 1'b1;
      case (opcode.grp.aaa)
        AAA_ORA: ctrl.aluOp = ALU_OR;
        AAA_AND: ctrl.aluOp = ALU_AND;
        AAA_EOR: ctrl.aluOp = ALU_EOR;
        AAA_ADC: begin
          ctrl.aluOp    = ALU_SUM;
          ctrl.flagMode = FLAGS_NZVC;
        end
        // operand rides the bus into holdA
        AAA_LDA: ctrl.busSrc = BUS_OPERAND;
        AAA_CMP: begin
          ctrl.aluOp         = ALU_SUM;
          ctrl.invertB       = 1'b1;
          ctrl.carryFromFlag = 1'b0;
          ctrl.regDest       = DEST_NONE;
          ctrl.flagMode      = FLAGS_NZC;
        end
        AAA_SBC: begin
          ctrl.aluOp    = ALU_SUM;
          ctrl.invertB  = 1'b1;
          ctrl.flagMode = FLAGS_NZVC;
        end
        // no store without memory
        AAA_STA: illegal = 1'b1;
        default: illegal = 1'b1;
      endcase
    end else begin
      // implied ops by whole byte
      case (opcode.raw)
        OP_TAX: {ctrl.busSrc, ctrl.regDest, ctrl.flagMode} = {BUS_A, DEST_X, FLAGS_NZ};
        OP_TAY: {ctrl.busSrc, ctrl.regDest, ctrl.flagMode} = {BUS_A, DEST_Y, FLAGS_NZ};
        OP_TXA: {ctrl.busSrc, ctrl.regDest, ctrl.flagMode} = {BUS_X, DEST_A, FLAGS_NZ};
        OP_TYA: {ctrl.busSrc, ctrl.regDest, ctrl.flagMode} = {BUS_Y, DEST_A, FLAGS_NZ};
        OP_TSX: {ctrl.busSrc, ctrl.regDest, ctrl.flagMode} = {BUS_S, DEST_X, FLAGS_NZ};
        // stack load, flags untouched
        OP_TXS: {ctrl.busSrc, ctrl.regDest} = {BUS_X, DEST_S};
        OP_CLC: ctrl.flagOp = FOP_CLC;
        OP_SEC: ctrl.flagOp = FOP_SEC;
        OP_CLI: ctrl.flagOp = FOP_CLI;
        OP_SEI: ctrl.flagOp = FOP_SEI;
        OP_CLV: ctrl.flagOp = FOP_CLV;
        OP_NOP: illegal = 1'b0;
        default: illegal = 1'b1;
      endcase
    end
  end

endmodule

// File: hdl/execSequencer.sv
`timescale 1ns/1ps
/* T-state walk for one instruction, read step then write step */
module execSequencer (
  input  logic                 phi2,
  input  logic                 rstN,
  input  logic                 issue,
  input  mos6502Pkg::ctrlWordT issueCtrl,
  output logic                 busy,
  output logic                 readStep,
  output logic                 writeStep,
  output mos6502Pkg::ctrlWordT heldCtrl
);
  import mos6502Pkg::*;

  typedef enum logic [1:0] {T_IDLE, T_READ, T_WRITE} tStateT;

  tStateT   tReg;
  tStateT   tNow;
  ctrlWordT ctrlHold;

  // issue opens the read step in its own cycle
  assign tNow = issue ? T_READ : tReg;

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      tReg     <= T_IDLE;
      ctrlHold <= '0;
    end else begin
      // read is always followed by write, then idle
      tReg <= (tNow == T_READ) ? T_WRITE : T_IDLE;
      if (issue)
        ctrlHold <= issueCtrl;
    end
  end

  assign readStep  = (tNow == T_READ);
  assign writeStep = (tNow == T_WRITE);
  assign busy      = (tNow != T_IDLE);

  // control word valid in both steps
  assign heldCtrl = issue ? issueCtrl : ctrlHold;

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps
/* A, X, Y and S with the special bus select and the ALU input holds */
module registerFile (
  input  logic                          phi2,
  input  logic                          rstN,
  input  logic                          readStep,
  input  logic                          writeStep,
  input  mos6502Pkg::busSrcT            busSrc,
  input  mos6502Pkg::regDestT           regDest,
  input  logic [mos6502Pkg::DATA_W-1:0] operand,
  input  mos6502Pkg::aluResultT         result,
  output logic [mos6502Pkg::DATA_W-1:0] holdA,
  output logic [mos6502Pkg::DATA_W-1:0] holdB,
  output logic [mos6502Pkg::DATA_W-1:0] regA,
  output logic [mos6502Pkg::DATA_W-1:0] regX,
  output logic [mos6502Pkg::DATA_W-1:0] regY,
  output logic [mos6502Pkg::DATA_W-1:0] regS
);
  import mos6502Pkg::*;

  logic [DATA_W-1:0] sb;

  // internal special bus, one driver per step
  always_comb begin
    case (busSrc)
      BUS_A:   sb = regA;
      BUS_X:   sb = regX;
      BUS_Y:   sb = regY;
      BUS_S:   sb = regS;
      default: sb = operand;
    endcase
  end

  // ALU holds load at the end of the read step
  always_ff @(posedge phi2) begin
    if (readStep) begin
      holdA <= sb;
      holdB <= operand;
    end
  end

  // writeback at the end of the write step
  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      regA <= REG_RESET;
      regX <= REG_RESET;
      regY <= REG_RESET;
      regS <= S_RESET;
    end else if (writeStep) begin
      case (regDest)
        DEST_A:  regA <= result.data;
        DEST_X:  regX <= result.data;
        DEST_Y:  regY <= result.data;
        DEST_S:  regS <= result.data;
        default: regA <= regA;
      endcase
    end
  end

endmodule

// File: hdl/aluCore.sv
`timescale 1ns/1ps
/* binary ALU, logic ops, sum with carry and pass, with C V Z N */
module aluCore (
  input  logic [mos6502Pkg::DATA_W-1:0] holdA,
  input  logic [mos6502Pkg::DATA_W-1:0] holdB,
  input  mos6502Pkg::aluOpT             aluOp,
  input  logic                          invertB,
  input  logic                          carryFromFlag,
  input  logic                          carryFlag,
  output mos6502Pkg::aluResultT         result
);
  import mos6502Pkg::*;

  logic [DATA_W-1:0] bIn;
  logic              cIn;
  logic [DATA_W:0]   sum;
  logic [DATA_W-1:0] res;
  logic              carry;
  logic              overflow;

  // one's complement of B for SBC and CMP
  assign bIn = invertB ? ~holdB : holdB;
  // CMP forces carry in, no borrow
  assign cIn = carryFromFlag ? carryFlag : 1'b1;
  assign sum = {1'b0, holdA} + {1'b0, bIn} + {{DATA_W{1'b0}}, cIn};

  always_comb begin
    res      = holdA;
    carry    = 1'b0;
    overflow = 1'b0;
    case (aluOp)
      ALU_OR:  res = holdA | holdB;
      ALU_AND: res = holdA & holdB;
      ALU_EOR: res = holdA ^ holdB;
      ALU_SUM: begin
        res   = sum[DATA_W-1:0];
        carry = sum[DATA_W];
        // same sign in, other sign out
        overflow = (holdA[DATA_W-1] == bIn[DATA_W-1]) &&
                   (res[DATA_W-1] != holdA[DATA_W-1]);
      end
      default: res = holdA;
    endcase
  end

  always_comb begin
    result.data     = res;
    result.carry    = carry;
    result.overflow = overflow;
    result.zero     = (res == '0);
    result.negative = res[DATA_W-1];
  end

endmodule

// File: hdl/statusRegister.sv
`timescale 1ns/1ps
/* processor status flags, ALU updates and direct flag ops */
module statusRegister (
  input  logic                  phi2,
  input  logic                  rstN,
  input  logic                  writeStep,
  input  mos6502Pkg::flagModeT  flagMode,
  input  mos6502Pkg::flagOpT    flagOp,
  input  mos6502Pkg::aluResultT result,
  output mos6502Pkg::statusT    status
);
  import mos6502Pkg::*;

  logic nFlag;
  logic vFlag;
  logic iFlag;
  logic zFlag;
  logic cFlag;

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      nFlag <= P_RESET[7];
      vFlag <= P_RESET[6];
      iFlag <= P_RESET[2];
      zFlag <= P_RESET[1];
      cFlag <= P_RESET[0];
    end else if (writeStep) begin
      // NZ for every mode but none
      if (flagMode != FLAGS_NONE) begin
        nFlag <= result.negative;
        zFlag <= result.zero;
      end
      if (flagMode == FLAGS_NZC || flagMode == FLAGS_NZVC)
        cFlag <= result.carry;
      if (flagMode == FLAGS_NZVC)
        vFlag <= result.overflow;
      case (flagOp)
        FOP_CLC: cFlag <= 1'b0;
        FOP_SEC: cFlag <= 1'b1;
        FOP_CLI: iFlag <= 1'b0;
        FOP_SEI: iFlag <= 1'b1;
        FOP_CLV: vFlag <= 1'b0;
        default: iFlag <= iFlag;
      endcase
    end
  end

  // unused bit reads one, no B and no decimal mode
  always_comb begin
    status.n   = nFlag;
    status.v   = vFlag;
    status.one = 1'b1;
    status.b   = 1'b0;
    status.d   = 1'b0;
    status.i   = iFlag;
    status.z   = zFlag;
    status.c   = cFlag;
  end

endmodule

// File: hdl/cpuCore6502.sv
`timescale 1ns/1ps
/* core top, APB host port around the 6502 datapath */
module cpuCore6502 (
  input  logic                              phi2,
  input  logic                              rstN,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [mos6502Pkg::APB_ADDR_W-1:0] paddr,
  input  logic [mos6502Pkg::APB_DATA_W-1:0] pwdata,
  output logic [mos6502Pkg::APB_DATA_W-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr
);
  import mos6502Pkg::*;

  opcodeWordT        opcode;
  ctrlWordT          ctrl;
  ctrlWordT          issueCtrl;
  ctrlWordT          heldCtrl;
  logic              illegal;
  logic              busy;
  logic              issue;
  logic              readStep;
  logic              writeStep;
  logic [DATA_W-1:0] operand;
  logic [DATA_W-1:0] holdA;
  logic [DATA_W-1:0] holdB;
  logic [DATA_W-1:0] regA;
  logic [DATA_W-1:0] regX;
  logic [DATA_W-1:0] regY;
  logic [DATA_W-1:0] regS;
  aluResultT         aluResult;
  statusT            status;

  apbHostPort host_i (.phi2, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .pready, .pslverr, .opcode, .ctrl, .illegal, .busy, .issue, .issueCtrl, .operand,
    .regA, .regX, .regY, .regS, .status);

  opcodeDecode decode_i (.opcode, .ctrl, .illegal);

  execSequencer seq_i (.phi2, .rstN, .issue, .issueCtrl, .busy, .readStep, .writeStep,
    .heldCtrl);

  // bus source in the read step, destination in the write step
  registerFile regs_i (.phi2, .rstN, .readStep, .writeStep, .busSrc(heldCtrl.busSrc),
    .regDest(heldCtrl.regDest), .operand, .result(aluResult), .holdA, .holdB,
    .regA, .regX, .regY, .regS);

  aluCore alu_i (.holdA, .holdB, .aluOp(heldCtrl.aluOp), .invertB(heldCtrl.invertB),
    .carryFromFlag(heldCtrl.carryFromFlag), .carryFlag(status.c), .result(aluResult));

  statusRegister sr_i (.phi2, .rstN, .writeStep, .flagMode(heldCtrl.flagMode),
    .flagOp(heldCtrl.flagOp), .result(aluResult), .status);

endmodule

// File: test/cpuChecker.sv
`timescale 1ns/1ps
/* APB watcher with a reference model of A, X, Y, S and P
   compares read data and error responses, counts wait states */
module cpuChecker (
  input  logic                              phi2,
  input  logic                              rstN,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [mos6502Pkg::APB_ADDR_W-1:0] paddr,
  input  logic [mos6502Pkg::APB_DATA_W-1:0] pwdata,
  input  logic [mos6502Pkg::APB_DATA_W-1:0] prdata,
  input  logic                              pready,
  input  logic                              pslverr,
  output int                                errorCount,
  output int                                checkCount,
  output int                                stallCount
);
  import mos6502Pkg::*;

  // flag positions in P
  localparam int P_N = 7;
  localparam int P_V = 6;
  localparam int P_I = 2;
  localparam int P_Z = 1;
  localparam int P_C = 0;

  typedef struct packed {
    logic [15:0] instr;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  s;
    logic [7:0]  p;
  } modelT;

  modelT       model;
  int          errors = 0;
  int          checks = 0;
  int          stalls = 0;
  int          busyLeft = 0;
  logic        coreBusy;
  logic        expErr;
  logic [32:0] expRead;

  assign errorCount = errors;
  assign checkCount = checks;
  assign stallCount = stalls;

  function automatic logic [7:0] withNZ(logic [7:0] p, logic [7:0] value);
    logic [7:0] q;
    q      = p;
    q[P_N] = value[7];
    q[P_Z] = (value == 8'h00);
    return q;
  endfunction

  function automatic logic isLegal(logic [7:0] op);
    case (op)
      8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9: return 1'b1;
      OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS: return 1'b1;
      OP_CLC, OP_SEC, OP_CLI, OP_SEI, OP_CLV, OP_NOP: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // next model state for one legal instruction
  function automatic modelT refExecute(modelT st, logic [7:0] op, logic [7:0] imm);
    modelT      nx;
    logic [8:0] wide;
    logic [7:0] r;
    nx       = st;
    nx.instr = {imm, op};
    r        = st.a;
    case (op)
      8'h09: r = st.a | imm;
      8'h29: r = st.a & imm;
      8'h49: r = st.a ^ imm;
      8'hA9: r = imm;
      8'h69: begin
        wide        = st.a + imm + st.p[P_C];
        r           = wide[7:0];
        nx.p[P_C]   = wide[8];
        nx.p[P_V]   = ((st.a ^ r) & (imm ^ r) & 8'h80) != 8'h00;
      end
      // borrow is the inverse of C
      8'hE9: begin
        wide        = {1'b0, st.a} - {1'b0, imm} - {8'h00, ~st.p[P_C]};
        r           = wide[7:0];
        nx.p[P_C]   = ~wide[8];
        nx.p[P_V]   = ((st.a ^ imm) & (st.a ^ r) & 8'h80) != 8'h00;
      end
      8'hC9: begin
        r         = st.a - imm;
        nx.p[P_C] = (st.a >= imm);
      end
      OP_TAX, OP_TAY: r = st.a;
      OP_TXA, OP_TXS: r = st.x;
      OP_TYA: r = st.y;
      OP_TSX: r = st.s;
      default: r = st.a;
    endcase
    // destination and direct flag ops
    case (op)
      OP_TAX, OP_TSX: nx.x = r;
      OP_TAY: nx.y = r;
      OP_TXS: nx.s = r;
      OP_CLC: nx.p[P_C] = 1'b0;
      OP_SEC: nx.p[P_C] = 1'b1;
      OP_CLI: nx.p[P_I] = 1'b0;
      OP_SEI: nx.p[P_I] = 1'b1;
      OP_CLV: nx.p[P_V] = 1'b0;
      OP_NOP, 8'hC9: begin
      end
      default: nx.a = r;
    endcase
    // TXS and flag ops keep N and Z
    case (op)
      OP_TXS, OP_CLC, OP_SEC, OP_CLI, OP_SEI, OP_CLV, OP_NOP: begin
      end
      default: nx.p = withNZ(nx.p, r);
    endcase
    return nx;
  endfunction

  // error flag on top, then read data
  function automatic logic [32:0] expectedRead(modelT st, logic [7:0] addr);
    case (addr)
      ADDR_INSTR: return {1'b0, 16'h0000, st.instr};
      ADDR_A:     return {1'b0, 24'h000000, st.a};
      ADDR_X:     return {1'b0, 24'h000000, st.x};
      ADDR_Y:     return {1'b0, 24'h000000, st.y};
      ADDR_S:     return {1'b0, 24'h000000, st.s};
      ADDR_P:     return {1'b0, 24'h000000, st.p};
      default:    return {1'b1, 32'h00000000};
    endcase
  endfunction

  function automatic string regLabel(logic [7:0] addr);
    case (addr)
      ADDR_INSTR: return "prdata(INSTR)";
      ADDR_A:     return "prdata(A)";
      ADDR_X:     return "prdata(X)";
      ADDR_Y:     return "prdata(Y)";
      ADDR_S:     return "prdata(S)";
      ADDR_P:     return "prdata(P)";
      default:    return "prdata(unmapped)";
    endcase
  endfunction

  task automatic compareValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
    checks = checks + 1;
    if (expVal !== gotVal) begin
      errors = errors + 1;
      $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, expVal, gotVal, $time);
    end
  endtask

  task automatic reportProblem(input string what);
    errors = errors + 1;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // sampled mid cycle, a transfer seen here completes on the next rising edge
  always @(negedge phi2) begin
    if (!rstN) begin
      model.instr = 16'h0000;
      model.a     = 8'h00;
      model.x     = 8'h00;
      model.y     = 8'h00;
      model.s     = 8'hFF;
      model.p     = 8'h24;
      busyLeft    = 0;
    end else begin
      coreBusy = (busyLeft > 0);
      if (busyLeft > 0)
        busyLeft = busyLeft - 1;
      if (psel && penable && !pready) begin
        stalls = stalls + 1;
        if (!coreBusy)
          reportProblem("pready held low while the core is idle");
      end
      if (psel && penable && pready) begin
        if (coreBusy)
          reportProblem("transfer completed while the core was still executing");
        if (pwrite) begin
          expErr = (paddr != ADDR_INSTR) || !isLegal(pwdata[7:0]);
          compareValue("pslverr", {31'd0, expErr}, {31'd0, pslverr});
          if (!expErr) begin
            model    = refExecute(model, pwdata[7:0], pwdata[15:8]);
            busyLeft = 2;
          end
        end else begin
          expRead = expectedRead(model, paddr);
          compareValue(regLabel(paddr), expRead[31:0], prdata);
          compareValue("pslverr", {31'd0, expRead[32]}, {31'd0, pslverr});
        end
      end else if (pslverr) begin
        reportProblem("pslverr raised outside a completing transfer");
      end
    end
  end

endmodule

// File: test/cpuCoreTb.sv
`timescale 1ns/1ps
/* testbench top for the APB hosted 6502 core
   clock, reset, APB stimulus, DUT, checker and watchdog */
module cpuCoreTb;
  import mos6502Pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY  = 1;
  localparam int N_LOGIC      = 6;
  localparam int N_ARITH      = 8;
  localparam int N_XFER       = 4;
  localparam int N_BACK       = 4;
  // transfers issued by each test below
  localparam int TRANSFERS = 6 + N_LOGIC * 12 + N_ARITH * 13 + N_XFER * 21 + 15 + 21
                             + N_BACK * 6;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TRANSFERS * 10;

  // immediate group 1 opcodes
  localparam logic [7:0] OP_ORA_IMM = 8'h09;
  localparam logic [7:0] OP_AND_IMM = 8'h29;
  localparam logic [7:0] OP_EOR_IMM = 8'h49;
  localparam logic [7:0] OP_ADC_IMM = 8'h69;
  localparam logic [7:0] OP_LDA_IMM = 8'hA9;
  localparam logic [7:0] OP_CMP_IMM = 8'hC9;
  localparam logic [7:0] OP_SBC_IMM = 8'hE9;

  logic        phi2;
  logic        rstN;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          seed = 88;
  int          errorCount;
  int          checkCount;
  int          stallCount;

  cpuCore6502 dut_i (.phi2, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .pready, .pslverr);

  cpuChecker check_i (.phi2, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .pready, .pslverr, .errorCount, .checkCount, .stallCount);

  initial begin
    phi2 = 1'b0;
    forever #(CLK_PERIOD / 2) phi2 = ~phi2;
  end

  function automatic logic [7:0] randByte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [7:0] illegalOpcode(int k);
    case (k)
      0:       return 8'h89;
      1:       return 8'hF8;
      2:       return 8'hD8;
      3:       return 8'h00;
      4:       return 8'h65;
      default: return 8'h02;
    endcase
  endfunction

  // entered just after a rising edge with the setup phase already driven
  task automatic finishAccess();
    @(posedge phi2);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(negedge phi2);
    while (!pready)
      @(negedge phi2);
    @(posedge phi2);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    finishAccess();
  endtask

  task automatic apbRead(input logic [7:0] addr);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    pwdata  = 32'h0;
    finishAccess();
  endtask

  task automatic execInstr(input logic [7:0] op, input logic [7:0] imm);
    apbWrite(ADDR_INSTR, {16'h0000, imm, op});
  endtask

  task automatic execReadA(input logic [7:0] op, input logic [7:0] imm);
    execInstr(op, imm);
    apbRead(ADDR_A);
    apbRead(ADDR_P);
  endtask

  task automatic execReadP(input logic [7:0] op);
    execInstr(op, 8'h00);
    apbRead(ADDR_P);
  endtask

  task automatic setRandomCarry();
    logic [7:0] r;
    r = randByte();
    execInstr(r[0] ? OP_SEC : OP_CLC, 8'h00);
  endtask

  task automatic checkResetState();
    apbRead(ADDR_A);
    apbRead(ADDR_X);
    apbRead(ADDR_Y);
    apbRead(ADDR_S);
    apbRead(ADDR_P);
    apbRead(ADDR_INSTR);
  endtask

  task automatic runLogicOps();
    for (int i = 0; i < N_LOGIC; i++) begin
      execReadA(OP_LDA_IMM, randByte());
      execReadA(OP_ORA_IMM, randByte());
      execReadA(OP_AND_IMM, randByte());
      execReadA(OP_EOR_IMM, randByte());
    end
  endtask

  task automatic runArithmetic();
    for (int i = 0; i < N_ARITH; i++) begin
      execInstr(OP_LDA_IMM, randByte());
      setRandomCarry();
      execReadA(OP_ADC_IMM, randByte());
      execInstr(OP_LDA_IMM, randByte());
      setRandomCarry();
      execReadA(OP_SBC_IMM, randByte());
      execReadA(OP_CMP_IMM, randByte());
    end
  endtask

  // each flag setting transfer starts from N and Z of another value
  task automatic runTransfers();
    for (int i = 0; i < N_XFER; i++) begin
      execInstr(OP_LDA_IMM, randByte());
      // N and Z from the old S before TAX
      execInstr(OP_TSX, 8'h00);
      execInstr(OP_TAX, 8'h00);
      apbRead(ADDR_P);
      // Z set here so a flag change by TXS shows in P
      execInstr(OP_LDA_IMM, 8'h00);
      execInstr(OP_TXS, 8'h00);
      apbRead(ADDR_S);
      apbRead(ADDR_P);
      execInstr(OP_LDA_IMM, randByte());
      execInstr(OP_TSX, 8'h00);
      apbRead(ADDR_P);
      execInstr(OP_TAY, 8'h00);
      apbRead(ADDR_X);
      apbRead(ADDR_Y);
      apbRead(ADDR_P);
      execReadA(OP_TXA, 8'h00);
      execReadA(OP_TYA, 8'h00);
    end
  endtask

  task automatic runFlagOps();
    execReadP(OP_SEI);
    execReadP(OP_CLI);
    // 7F plus 01 overflows into the sign bit
    execInstr(OP_LDA_IMM, 8'h7F);
    execInstr(OP_CLC, 8'h00);
    execReadA(OP_ADC_IMM, 8'h01);
    execReadP(OP_CLV);
    execReadP(OP_NOP);
    execReadP(OP_SEI);
  endtask

  task automatic runErrorCases();
    for (int k = 0; k < 6; k++) begin
      execInstr(illegalOpcode(k), randByte());
      apbRead(ADDR_A);
    end
    // read-only and unmapped addresses
    apbWrite(ADDR_A, 32'h0000_0055);
    apbWrite(ADDR_P, 32'h0000_00FF);
    apbWrite(8'h18, 32'h0000_A9A9);
    apbRead(ADDR_X);
    apbRead(ADDR_Y);
    apbRead(ADDR_S);
    apbRead(ADDR_P);
    apbRead(ADDR_INSTR);
    apbRead(8'h18);
  endtask

  // each access starts in the cycle after the previous one completes
  task automatic runBackToBack();
    for (int i = 0; i < N_BACK; i++) begin
      execInstr(OP_LDA_IMM, randByte());
      apbRead(ADDR_A);
      execInstr(OP_TAX, 8'h00);
      execInstr(OP_ADC_IMM, randByte());
      apbRead(ADDR_X);
      apbRead(ADDR_A);
    end
  endtask

  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'h00;
    pwdata  = 32'h0;
    rstN    = 1'b0;
    repeat (RESET_CYCLES) @(posedge phi2);
    #DRIVE_DELAY;
    rstN = 1'b1;
    @(posedge phi2);
    #DRIVE_DELAY;
    checkResetState();
    runLogicOps();
    runArithmetic();
    runTransfers();
    runFlagOps();
    runErrorCases();
    runBackToBack();
    repeat (2) @(posedge phi2);
    $display("errors: %0d  checks: %0d  wait cycles: %0d", errorCount, checkCount, stallCount);
    if (errorCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge phi2);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: build.f
hdl/mos6502Pkg.sv
hdl/apbHostPort.sv
hdl/opcodeDecode.sv
hdl/execSequencer.sv
hdl/registerFile.sv
hdl/aluCore.sv
hdl/statusRegister.sv
hdl/cpuCore6502.sv
test/cpuChecker.sv
test/cpuCoreTb.sv
